// ==== acq_config.svh ====
`ifndef ACQ_CONFIG_SVH
`define ACQ_CONFIG_SVH

// Raw ADC word width in two's complement
`define ACQ_ADC_W 14

// Width of one stored sample after sign extension
`define ACQ_SAMPLE_W 16

// Sample memory geometry
`define ACQ_ADDR_W 8
`define ACQ_MEM_DEPTH 256

// One step of the size parameter selects this many samples
`define ACQ_SIZE_STEP 16
`define ACQ_DEF_SIZE_PARAM 3

// UART bit time in sys_clock cycles
`define ACQ_CLKS_PER_BIT 16

`endif

// ==== acq_ctrl_pkg.sv ====
package acq_ctrl_pkg;

    // Capture sequence state that is also brought out on o_status
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_CLEAN  = 2'd1,
        ST_SAMPLE = 2'd2,
        ST_DUMP   = 2'd3
    } acq_status_e;

    // Opcode in the upper nibble of a command byte while the lower nibble carries the parameter
    typedef enum logic [3:0] {
        OP_SET_SIZE  = 4'd1,
        OP_SET_DECIM = 4'd2,
        OP_START     = 4'd3
    } acq_op_e;

    // Bit positions inside a command byte
    localparam int CMD_OP_MSB    = 7;
    localparam int CMD_OP_LSB    = 4;
    localparam int CMD_PARAM_MSB = 3;
    localparam int CMD_PARAM_LSB = 0;

endpackage

// ==== acq_data_pkg.sv ====
`include "acq_config.svh"

package acq_data_pkg;

    typedef logic signed [`ACQ_ADC_W-1:0] adc_word_t;

    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } byte_pair_t;

    // The sampler writes a signed value and the dump unit reads it back as two bytes
    typedef union packed {
        logic signed [`ACQ_SAMPLE_W-1:0] value;
        byte_pair_t                      bytes;
    } sample_word_u;

endpackage

// ==== uart_rx.sv ====
`timescale 1ns/1ps
`include "acq_config.svh"

module uart_rx (
    input  logic       sys_clock,
    input  logic       i_arst_n,
    input  logic       i_rx,
    output logic [7:0] o_data,
    output logic       o_valid
);

    localparam int CNT_W = $clog2(`ACQ_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`ACQ_CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] BIT_HALF = CNT_W'(`ACQ_CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e        state;
    logic             rx_meta;
    logic             rx_sync;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;

    // Two flops bring the asynchronous line into the clock domain
    always_ff @(posedge sys_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge sys_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            shift   <= '0;
            o_data  <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                // Recheck the start bit at its middle so that a glitch is not taken as a frame
                RX_START: begin
                    if (cnt == BIT_HALF) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == BIT_LAST) begin
                        cnt   <= '0;
                        shift <= {rx_sync, shift[7:1]};
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                        bit_idx <= bit_idx + 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (cnt == BIT_LAST) begin
                        // A low stop bit marks a framing error and the byte is dropped
                        o_valid <= rx_sync;
                        o_data  <= shift;
                        state   <= RX_IDLE;
                    end
                    cnt <= cnt + 1'b1;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps
`include "acq_config.svh"

module uart_tx (
    input  logic       sys_clock,
    input  logic       i_arst_n,
    input  logic       i_start,
    input  logic [7:0] i_data,
    output logic       o_tx,
    output logic       o_ready
);

    localparam int CNT_W = $clog2(`ACQ_CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`ACQ_CLKS_PER_BIT - 1);

    logic [CNT_W-1:0] cnt;
    logic [3:0]       bit_cnt;
    // Data bits followed by the stop bit since the start bit goes straight to the line
    logic [8:0]       frame;

    always_ff @(posedge sys_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_tx    <= 1'b1;
            o_ready <= 1'b1;
            cnt     <= '0;
            bit_cnt <= '0;
            frame   <= '1;
        end else if (o_ready) begin
            if (i_start) begin
                frame   <= {1'b1, i_data};
                o_tx    <= 1'b0;
                o_ready <= 1'b0;
                cnt     <= '0;
                bit_cnt <= '0;
            end
        end else if (cnt == BIT_LAST) begin
            cnt <= '0;
            if (bit_cnt == 4'd9) begin
                // The line is already high at the end of the stop bit
                o_ready <= 1'b1;
            end else begin
                o_tx    <= frame[0];
                frame   <= {1'b1, frame[8:1]};
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// ==== acq_fsm.sv ====
`timescale 1ns/1ps
`include "acq_config.svh"

module acq_fsm (
    input  logic                     sys_clock,
    input  logic                     i_arst_n,
    input  logic [7:0]               i_cmd,
    input  logic                     i_cmd_valid,
    input  logic                     i_clean_end,
    input  logic                     i_sample_end,
    input  logic                     i_dump_end,
    output acq_ctrl_pkg::acq_status_e o_status,
    output logic [`ACQ_ADDR_W:0]     o_memory_size,
    output logic [3:0]               o_decimator
);

    logic [3:0]              size_param;
    logic [3:0]              cmd_param;
    acq_ctrl_pkg::acq_op_e   cmd_op;
    logic [`ACQ_ADDR_W+4:0]  size_raw;

    assign cmd_op    = acq_ctrl_pkg::acq_op_e'(
        i_cmd[acq_ctrl_pkg::CMD_OP_MSB:acq_ctrl_pkg::CMD_OP_LSB]);
    assign cmd_param = i_cmd[acq_ctrl_pkg::CMD_PARAM_MSB:acq_ctrl_pkg::CMD_PARAM_LSB];

    // Samples per capture are limited to what the memory holds
    always_comb begin
        size_raw = ({{(`ACQ_ADDR_W+1){1'b0}}, size_param} + 1'b1) * `ACQ_SIZE_STEP;
        if (size_raw > `ACQ_MEM_DEPTH) begin
            o_memory_size = (`ACQ_ADDR_W+1)'(`ACQ_MEM_DEPTH);
        end else begin
            o_memory_size = size_raw[`ACQ_ADDR_W:0];
        end
    end

    always_ff @(posedge sys_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_status    <= acq_ctrl_pkg::ST_IDLE;
            size_param  <= 4'(`ACQ_DEF_SIZE_PARAM);
            o_decimator <= 4'd0;
        end else begin
            case (o_status)
                // Commands are accepted only between captures
                acq_ctrl_pkg::ST_IDLE: begin
                    if (i_cmd_valid) begin
                        case (cmd_op)
                            acq_ctrl_pkg::OP_SET_SIZE:  size_param  <= cmd_param;
                            acq_ctrl_pkg::OP_SET_DECIM: o_decimator <= cmd_param;
                            acq_ctrl_pkg::OP_START:     o_status    <= acq_ctrl_pkg::ST_CLEAN;
                            default: ;
                        endcase
                    end
                end
                acq_ctrl_pkg::ST_CLEAN: begin
                    if (i_clean_end) begin
                        o_status <= acq_ctrl_pkg::ST_SAMPLE;
                    end
                end
                acq_ctrl_pkg::ST_SAMPLE: begin
                    if (i_sample_end) begin
                        o_status <= acq_ctrl_pkg::ST_DUMP;
                    end
                end
                acq_ctrl_pkg::ST_DUMP: begin
                    if (i_dump_end) begin
                        o_status <= acq_ctrl_pkg::ST_IDLE;
                    end
                end
                default: o_status <= acq_ctrl_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

// ==== sampler.sv ====
`timescale 1ns/1ps
`include "acq_config.svh"

module sampler (
    input  logic                       sys_clock,
    input  logic                       i_arst_n,
    input  acq_ctrl_pkg::acq_status_e  i_status,
    input  logic                       i_gate,
    input  acq_data_pkg::adc_word_t    i_adc_data,
    input  logic [`ACQ_ADDR_W:0]       i_memory_size,
    input  logic [3:0]                 i_decimator,
    output logic                       o_wr_en,
    output logic [`ACQ_ADDR_W-1:0]     o_wr_addr,
    output acq_data_pkg::sample_word_u o_wr_data,
    output logic                       o_end
);

    logic       sampling;
    logic       last_addr;
    logic [3:0] decim_cnt;

    assign sampling  = (i_status == acq_ctrl_pkg::ST_SAMPLE);
    assign last_addr = ({1'b0, o_wr_addr} == i_memory_size - 1'b1);

    // A gated cycle is kept when the decimation counter is at zero
    // Nothing more is written once the end pulse is out
    assign o_wr_en = sampling && i_gate && (decim_cnt == 4'd0) && !o_end;

    always_comb begin
        o_wr_data.value = {{(`ACQ_SAMPLE_W-`ACQ_ADC_W){i_adc_data[`ACQ_ADC_W-1]}}, i_adc_data};
    end

    always_ff @(posedge sys_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            decim_cnt <= 4'd0;
            o_wr_addr <= '0;
            o_end     <= 1'b0;
        end else if (!sampling) begin
            decim_cnt <= 4'd0;
            o_wr_addr <= '0;
            o_end     <= 1'b0;
        end else begin
            // Cycles with the gate low do not advance the decimation
            if (i_gate) begin
                if (decim_cnt == i_decimator) begin
                    decim_cnt <= 4'd0;
                end else begin
                    decim_cnt <= decim_cnt + 1'b1;
                end
            end
            if (o_wr_en) begin
                o_wr_addr <= o_wr_addr + 1'b1;
            end
            o_end <= o_wr_en && last_addr;
        end
    end

endmodule

// ==== sample_memory.sv ====
`timescale 1ns/1ps
`include "acq_config.svh"

module sample_memory (
    input  logic                       sys_clock,
    input  logic                       i_arst_n,
    input  acq_ctrl_pkg::acq_status_e  i_status,
    input  logic [`ACQ_ADDR_W:0]       i_memory_size,
    input  logic                       i_wr_en,
    input  logic [`ACQ_ADDR_W-1:0]     i_wr_addr,
    input  acq_data_pkg::sample_word_u i_wr_data,
    input  logic [`ACQ_ADDR_W-1:0]     i_rd_addr,
    output acq_data_pkg::sample_word_u o_rd_data,
    output logic                       o_clean_end
);

    acq_data_pkg::sample_word_u mem [`ACQ_MEM_DEPTH];

    logic                   cleaning;
    logic                   clean_we;
    logic [`ACQ_ADDR_W-1:0] clean_addr;

    assign cleaning = (i_status == acq_ctrl_pkg::ST_CLEAN);
    assign clean_we = cleaning && !o_clean_end;

    // The clear sweep owns the write port during ST_CLEAN
    always_ff @(posedge sys_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            clean_addr  <= '0;
            o_clean_end <= 1'b0;
        end else if (!cleaning) begin
            clean_addr  <= '0;
            o_clean_end <= 1'b0;
        end else begin
            clean_addr  <= clean_addr + 1'b1;
            o_clean_end <= clean_we && ({1'b0, clean_addr} == i_memory_size - 1'b1);
        end
    end

    always_ff @(posedge sys_clock) begin
        if (clean_we) begin
            mem[clean_addr] <= '0;
        end else if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

// ==== dump_unit.sv ====
`timescale 1ns/1ps
`include "acq_config.svh"

module dump_unit (
    input  logic                       sys_clock,
    input  logic                       i_arst_n,
    input  acq_ctrl_pkg::acq_status_e  i_status,
    input  logic [`ACQ_ADDR_W:0]       i_memory_size,
    input  acq_data_pkg::sample_word_u i_rd_data,
    input  logic                       i_tx_ready,
    output logic [`ACQ_ADDR_W-1:0]     o_rd_addr,
    output logic                       o_tx_start,
    output logic [7:0]                 o_tx_byte,
    output logic                       o_end
);

    typedef enum logic [2:0] {D_ADDR, D_WAIT, D_LO, D_HI, D_FLUSH} dump_state_e;

    dump_state_e                state;
    acq_data_pkg::sample_word_u word;
    logic                       dumping;
    logic                       last_word;

    assign dumping   = (i_status == acq_ctrl_pkg::ST_DUMP);
    assign last_word = ({1'b0, o_rd_addr} == i_memory_size - 1'b1);

    assign o_tx_start = dumping && i_tx_ready && (state == D_LO || state == D_HI);
    assign o_tx_byte  = (state == D_LO) ? word.bytes.lo : word.bytes.hi;

    // The capture ends only when the last stop bit has left the line
    assign o_end = dumping && (state == D_FLUSH) && i_tx_ready;

    always_ff @(posedge sys_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state     <= D_ADDR;
            o_rd_addr <= '0;
        end else if (!dumping) begin
            state     <= D_ADDR;
            o_rd_addr <= '0;
        end else begin
            case (state)
                // The address is stable for one cycle before the registered read returns
                D_ADDR: state <= D_WAIT;
                D_WAIT: state <= D_LO;
                D_LO: begin
                    if (o_tx_start) begin
                        state <= D_HI;
                    end
                end
                D_HI: begin
                    if (o_tx_start) begin
                        if (last_word) begin
                            state <= D_FLUSH;
                        end else begin
                            o_rd_addr <= o_rd_addr + 1'b1;
                            state     <= D_ADDR;
                        end
                    end
                end
                D_FLUSH: begin
                    if (i_tx_ready) begin
                        state     <= D_ADDR;
                        o_rd_addr <= '0;
                    end
                end
                default: state <= D_ADDR;
            endcase
        end
    end

    always_ff @(posedge sys_clock) begin
        if (state == D_WAIT) begin
            word <= i_rd_data;
        end
    end

endmodule

// ==== acq_top.sv ====
`timescale 1ns/1ps
`include "acq_config.svh"

module acq_top (
    input  logic                      sys_clock,
    input  logic                      i_arst_n,
    input  logic                      i_rx,
    input  logic                      i_gate,
    input  logic [`ACQ_ADC_W-1:0]     i_adc_data,
    output logic                      o_tx,
    output acq_ctrl_pkg::acq_status_e o_status
);

    logic [7:0]                 rx_data;
    logic                       rx_valid;
    logic                       tx_ready;
    logic                       tx_start;
    logic [7:0]                 tx_byte;
    logic [`ACQ_ADDR_W:0]       memory_size;
    logic [3:0]                 decimator;
    logic                       wr_en;
    logic [`ACQ_ADDR_W-1:0]     wr_addr;
    acq_data_pkg::sample_word_u wr_data;
    logic                       sample_end;
    logic [`ACQ_ADDR_W-1:0]     rd_addr;
    acq_data_pkg::sample_word_u rd_data;
    logic                       clean_end;
    logic                       dump_end;

    uart_rx u_uart_rx (
        .sys_clock (sys_clock),
        .i_arst_n  (i_arst_n),
        .i_rx      (i_rx),
        .o_data    (rx_data),
        .o_valid   (rx_valid)
    );

    uart_tx u_uart_tx (
        .sys_clock (sys_clock),
        .i_arst_n  (i_arst_n),
        .i_start   (tx_start),
        .i_data    (tx_byte),
        .o_tx      (o_tx),
        .o_ready   (tx_ready)
    );

    acq_fsm u_acq_fsm (
        .sys_clock     (sys_clock),
        .i_arst_n      (i_arst_n),
        .i_cmd         (rx_data),
        .i_cmd_valid   (rx_valid),
        .i_clean_end   (clean_end),
        .i_sample_end  (sample_end),
        .i_dump_end    (dump_end),
        .o_status      (o_status),
        .o_memory_size (memory_size),
        .o_decimator   (decimator)
    );

    sampler u_sampler (
        .sys_clock     (sys_clock),
        .i_arst_n      (i_arst_n),
        .i_status      (o_status),
        .i_gate        (i_gate),
        .i_adc_data    (i_adc_data),
        .i_memory_size (memory_size),
        .i_decimator   (decimator),
        .o_wr_en       (wr_en),
        .o_wr_addr     (wr_addr),
        .o_wr_data     (wr_data),
        .o_end         (sample_end)
    );

    sample_memory u_sample_memory (
        .sys_clock     (sys_clock),
        .i_arst_n      (i_arst_n),
        .i_status      (o_status),
        .i_memory_size (memory_size),
        .i_wr_en       (wr_en),
        .i_wr_addr     (wr_addr),
        .i_wr_data     (wr_data),
        .i_rd_addr     (rd_addr),
        .o_rd_data     (rd_data),
        .o_clean_end   (clean_end)
    );

    dump_unit u_dump_unit (
        .sys_clock     (sys_clock),
        .i_arst_n      (i_arst_n),
        .i_status      (o_status),
        .i_memory_size (memory_size),
        .i_rd_data     (rd_data),
        .i_tx_ready    (tx_ready),
        .o_rd_addr     (rd_addr),
        .o_tx_start    (tx_start),
        .o_tx_byte     (tx_byte),
        .o_end         (dump_end)
    );

endmodule

// ==== acq_assertions.sv ====
`timescale 1ns/1ps
`include "acq_config.svh"

module acq_assertions (
    input logic                      sys_clock,
    input logic                      i_arst_n,
    input acq_ctrl_pkg::acq_status_e i_status,
    input logic                      i_tx,
    input logic                      i_wr_en,
    input logic [`ACQ_ADDR_W-1:0]    i_wr_addr,
    input logic [`ACQ_ADDR_W:0]      i_memory_size
);

    int error_count = 0;

    // The capture sequence only ever moves one step forward around the ring
    function automatic logic step_allowed(
        input acq_ctrl_pkg::acq_status_e prev,
        input acq_ctrl_pkg::acq_status_e cur
    );
        return (prev == acq_ctrl_pkg::ST_IDLE   && cur == acq_ctrl_pkg::ST_CLEAN)  ||
               (prev == acq_ctrl_pkg::ST_CLEAN  && cur == acq_ctrl_pkg::ST_SAMPLE) ||
               (prev == acq_ctrl_pkg::ST_SAMPLE && cur == acq_ctrl_pkg::ST_DUMP)   ||
               (prev == acq_ctrl_pkg::ST_DUMP   && cur == acq_ctrl_pkg::ST_IDLE);
    endfunction

    a_reset_state: assert property (@(posedge sys_clock)
        $rose(i_arst_n) |-> (i_status == acq_ctrl_pkg::ST_IDLE) && i_tx)
        else begin
            error_count = error_count + 1;
            $error("o_status not idle or o_tx low in the first cycle after reset");
        end

    // Nothing is transmitted before the dump phase
    a_tx_quiet: assert property (@(posedge sys_clock) disable iff (!i_arst_n)
        (i_status == acq_ctrl_pkg::ST_IDLE || i_status == acq_ctrl_pkg::ST_CLEAN) |-> i_tx)
        else begin
            error_count = error_count + 1;
            $error("o_tx went low while o_status was idle or clean");
        end

    a_status_order: assert property (@(posedge sys_clock) disable iff (!i_arst_n)
        (i_status != $past(i_status)) |-> step_allowed($past(i_status), i_status))
        else begin
            error_count = error_count + 1;
            $error("o_status took an illegal step");
        end

    // Writes stay in the sample phase and inside the selected capture size
    a_write_in_sample: assert property (@(posedge sys_clock) disable iff (!i_arst_n)
        i_wr_en |-> (i_status == acq_ctrl_pkg::ST_SAMPLE) &&
                    ({1'b0, i_wr_addr} < i_memory_size))
        else begin
            error_count = error_count + 1;
            $error("sampler wrote outside ST_SAMPLE or beyond the capture size");
        end

endmodule

bind acq_top acq_assertions u_acq_assertions (
    .sys_clock     (sys_clock),
    .i_arst_n      (i_arst_n),
    .i_status      (o_status),
    .i_tx          (o_tx),
    .i_wr_en       (wr_en),
    .i_wr_addr     (wr_addr),
    .i_memory_size (memory_size)
);

// ==== tb_acq_top.sv ====
`timescale 1ns/1ps
`include "acq_config.svh"

module tb_acq_top;

    localparam int CLKS        = `ACQ_CLKS_PER_BIT;
    localparam int START_WAIT  = 5000;
    localparam int GATE_LOW    = 0;
    localparam int GATE_HIGH   = 1;
    localparam int GATE_TOGGLE = 2;
    localparam int GATE_SPARSE = 3;

    logic                      sys_clock;
    logic                      i_arst_n;
    logic                      i_rx;
    logic                      i_gate;
    logic [`ACQ_ADC_W-1:0]     i_adc_data;
    logic                      o_tx;
    acq_ctrl_pkg::acq_status_e o_status;

    integer                    seed;
    logic [31:0]               rnd;
    int                        gate_mode;
    int                        cycle_cnt;
    // ADC words that met a high gate during ST_SAMPLE in arrival order
    logic [`ACQ_ADC_W-1:0]     gated_q[$];

    acq_top uut (
        .sys_clock  (sys_clock),
        .i_arst_n   (i_arst_n),
        .i_rx       (i_rx),
        .i_gate     (i_gate),
        .i_adc_data (i_adc_data),
        .o_tx       (o_tx),
        .o_status   (o_status)
    );

    initial sys_clock = 1'b0;
    always #4 sys_clock = ~sys_clock;

    task automatic fail_and_stop(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [`ACQ_SAMPLE_W-1:0] sign_extend(input logic [`ACQ_ADC_W-1:0] raw);
        int value;
        value = raw;
        // Words at or above half of the ADC range are negative in two's complement
        if (value >= (1 << (`ACQ_ADC_W - 1))) begin
            value = value - (1 << `ACQ_ADC_W);
        end
        return value[`ACQ_SAMPLE_W-1:0];
    endfunction

    // Gate and ADC word change together just after each rising edge
    always begin
        @(posedge sys_clock);
        #1;
        cycle_cnt = cycle_cnt + 1;
        case (gate_mode)
            GATE_HIGH:   i_gate = 1'b1;
            GATE_TOGGLE: i_gate = (cycle_cnt % 8) < 5;
            GATE_SPARSE: i_gate = (cycle_cnt % 8) == 0;
            default:     i_gate = 1'b0;
        endcase
        rnd = $random(seed);
        i_adc_data = rnd[`ACQ_ADC_W-1:0];
        if (i_gate && o_status == acq_ctrl_pkg::ST_SAMPLE) begin
            gated_q.push_back(i_adc_data);
        end
    end

    always @(negedge sys_clock) begin
        if (uut.u_acq_assertions.error_count != 0) begin
            fail_and_stop("a concurrent assertion on acq_top failed");
        end
    end

    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        int         b;
        frame = {1'b1, data, 1'b0};
        for (b = 0; b < 10; b++) begin
            @(posedge sys_clock);
            #1;
            i_rx = frame[b];
            repeat (CLKS - 1) @(posedge sys_clock);
        end
    endtask

    // Samples o_tx at falling edges in the middle of each bit
    task automatic recv_byte(output logic [7:0] data);
        int waited;
        int b;
        waited = 0;
        @(negedge sys_clock);
        while (o_tx !== 1'b0 && waited < START_WAIT) begin
            waited++;
            @(negedge sys_clock);
        end
        assert (o_tx === 1'b0) else fail_and_stop("no start bit appeared on o_tx in time");
        repeat (CLKS / 2) @(negedge sys_clock);
        assert (o_tx === 1'b0) else fail_and_stop("start bit on o_tx ended too early");
        for (b = 0; b < 8; b++) begin
            repeat (CLKS) @(negedge sys_clock);
            data[b] = o_tx;
        end
        repeat (CLKS) @(negedge sys_clock);
        assert (o_tx === 1'b1) else fail_and_stop("stop bit on o_tx was low");
    endtask

    task automatic wait_status(input acq_ctrl_pkg::acq_status_e want, input int limit,
                               input string what);
        int waited;
        waited = 0;
        @(negedge sys_clock);
        while (o_status != want && waited < limit) begin
            waited++;
            @(negedge sys_clock);
        end
        assert (o_status == want) else fail_and_stop(what);
    endtask

    task automatic hold_status(input acq_ctrl_pkg::acq_status_e want, input int cycles);
        int n;
        for (n = 0; n < cycles; n++) begin
            @(negedge sys_clock);
            assert (o_status == want)
                else fail_and_stop($sformatf("mismatch o_status: got 0x%0h, expected 0x%0h",
                                             o_status, want));
        end
    endtask

    task automatic start_capture();
        gated_q.delete();
        send_byte({acq_ctrl_pkg::OP_START, 4'd0});
    endtask

    // Word k of the dump must be gated sample k*step and its low byte comes first on the line
    task automatic check_dump(input int n_words, input int step);
        logic [7:0]              lo;
        logic [7:0]              hi;
        logic [`ACQ_SAMPLE_W-1:0] expected;
        int                      k;
        for (k = 0; k < n_words; k++) begin
            recv_byte(lo);
            recv_byte(hi);
            assert (gated_q.size() > k * step)
                else fail_and_stop("dump sent a word for a sample the gate never let through");
            expected = sign_extend(gated_q[k * step]);
            assert ({hi, lo} == expected)
                else fail_and_stop($sformatf("mismatch o_tx word %0d: got 0x%04h, expected 0x%04h",
                                             k, {hi, lo}, expected));
        end
        // A longer dump would start another byte instead of going idle
        wait_status(acq_ctrl_pkg::ST_IDLE, 2 * CLKS,
                    "o_status did not return to idle after the expected number of bytes");
    endtask

    initial begin
        seed       = 77882;
        gate_mode  = GATE_LOW;
        cycle_cnt  = 0;
        i_arst_n   = 1'b0;
        i_rx       = 1'b1;
        i_gate     = 1'b0;
        i_adc_data = '0;
        repeat (10) @(posedge sys_clock);
        #1;
        i_arst_n = 1'b1;
        hold_status(acq_ctrl_pkg::ST_IDLE, 8);

        // Reset settings give 64 words with every gated sample kept
        gate_mode = GATE_HIGH;
        start_capture();
        check_dump(64, 1);

        send_byte({acq_ctrl_pkg::OP_SET_DECIM, 4'd2});
        send_byte({acq_ctrl_pkg::OP_SET_SIZE, 4'd0});
        hold_status(acq_ctrl_pkg::ST_IDLE, 4);
        gate_mode = GATE_TOGGLE;
        start_capture();
        check_dump(16, 3);

        // Sparse gate keeps the sample phase open long enough for a whole command
        gate_mode = GATE_SPARSE;
        start_capture();
        wait_status(acq_ctrl_pkg::ST_SAMPLE, 200, "capture never reached the sample phase");
        send_byte({acq_ctrl_pkg::OP_SET_SIZE, 4'd5});
        hold_status(acq_ctrl_pkg::ST_SAMPLE, 1);
        check_dump(16, 3);

        // Opcode 7 is not defined
        send_byte({4'd7, 4'd10});
        hold_status(acq_ctrl_pkg::ST_IDLE, 3 * CLKS);
        gate_mode = GATE_TOGGLE;
        start_capture();
        check_dump(16, 3);

        @(negedge sys_clock);
        if (uut.u_acq_assertions.error_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            fail_and_stop("concurrent assertions on acq_top reported errors");
        end
    end

endmodule

// ==== sim.f ====
+incdir+.
acq_ctrl_pkg.sv
acq_data_pkg.sv
uart_rx.sv
uart_tx.sv
acq_fsm.sv
sampler.sv
sample_memory.sv
dump_unit.sv
acq_top.sv
acq_assertions.sv
tb_acq_top.sv
